//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // datapath width
    localparam int xlen  = 32;
    localparam int imm_w = 12;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] data_t;

    // flag register bit positions
    localparam int fl_zero = 0;
    localparam int fl_neg  = 1;
    typedef logic [1:0] flags_t;

    // opcodes, anything else is a nop
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_and  = 5'd3,
        op_or   = 5'd4,
        op_xor  = 5'd5,
        op_addi = 5'd6,  // rs1 + sext(imm)
        op_cmp  = 5'd7,  // flags from rs1 - rs2, no reg write
        op_rdfl = 5'd8   // rd = zext(flags)
    } opcode_t;

    // instruction word, msb first
    typedef struct packed {
        logic [4:0]       opcode;  // 31:27
        reg_idx_t         rd;      // 26:22
        reg_idx_t         rs1;     // 21:17
        reg_idx_t         rs2;     // 16:12
        logic [imm_w-1:0] imm;     // 11:0
    } instr_t;

    // alu function
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_flags  // pass flags out as data
    } alu_op_t;

endpackage

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    //////////////////////////////////////////////////
    // decode -> execute payload
    typedef struct packed {
        logic    valid;
        alu_op_t alu_op;
        logic    use_imm;   // operand b from imm
        logic    reg_wr;
        logic    fl_write;
        // register selects, also used for forwarding
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    rs1_data;
        data_t    rs2_data;
        data_t    imm;      // already sign extended
        flags_t   flags;    // architectural flags seen at decode
    } de_ex_t;

    //////////////////////////////////////////////////
    // execute result, carried through exme and mewb
    typedef struct packed {
        logic     valid;
        logic     reg_wr;
        reg_idx_t rd;
        data_t    data;
        logic     fl_write;
        flags_t   flags;
    } result_t;

    // operand source select
    typedef enum logic [1:0] {
        from_stage,  // value carried in deex
        from_exme,   // one ahead
        from_mewb    // two ahead
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  wire  isa_pkg::data_t    instr,
    input  wire  logic              instr_valid,
    output       isa_pkg::reg_idx_t rs1,
    output       isa_pkg::reg_idx_t rs2,
    input  wire  isa_pkg::data_t    rs1_data,
    input  wire  isa_pkg::data_t    rs2_data,
    input  wire  isa_pkg::flags_t   flags,
    output       pipe_pkg::de_ex_t  decoded
);

    import isa_pkg::*;

    instr_t fields;

    assign fields = instr;

    // read selects go straight to the register file
    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;

    always_comb begin
        // defaults describe a nop
        decoded          = '0;
        decoded.valid    = instr_valid;
        decoded.alu_op   = alu_add;
        decoded.rd       = fields.rd;
        decoded.rs1      = fields.rs1;
        decoded.rs2      = fields.rs2;
        decoded.rs1_data = rs1_data;
        decoded.rs2_data = rs2_data;
        decoded.flags    = flags;
        // sign extend imm
        decoded.imm = {{(xlen-imm_w){fields.imm[imm_w-1]}}, fields.imm};

        case (fields.opcode)
            op_add: begin
                decoded.alu_op = alu_add;
                decoded.reg_wr = 1'b1;
            end
            op_sub: begin
                decoded.alu_op = alu_sub;
                decoded.reg_wr = 1'b1;
            end
            op_and: begin
                decoded.alu_op = alu_and;
                decoded.reg_wr = 1'b1;
            end
            op_or: begin
                decoded.alu_op = alu_or;
                decoded.reg_wr = 1'b1;
            end
            op_xor: begin
                decoded.alu_op = alu_xor;
                decoded.reg_wr = 1'b1;
            end
            op_addi: begin
                decoded.alu_op  = alu_add;
                decoded.use_imm = 1'b1;
                decoded.reg_wr  = 1'b1;
            end
            // compare only touches flags
            op_cmp: begin
                decoded.alu_op   = alu_sub;
                decoded.fl_write = 1'b1;
            end
            op_rdfl: begin
                decoded.alu_op = alu_flags;
                decoded.reg_wr = 1'b1;
            end
            default: begin
                // nop and unknown opcodes
                decoded.reg_wr   = 1'b0;
                decoded.fl_write = 1'b0;
            end
        endcase

        // r0 is never written
        if (fields.rd == '0) begin
            decoded.reg_wr = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file #(
    parameter int reg_count = 32
) (
    input  wire  logic              clk,
    input  wire  logic              rst,
    input  wire  isa_pkg::reg_idx_t rs1,
    input  wire  isa_pkg::reg_idx_t rs2,
    output       isa_pkg::data_t    rs1_data,
    output       isa_pkg::data_t    rs2_data,
    input  wire  pipe_pkg::result_t wb,
    output       isa_pkg::flags_t   flags
);

    import isa_pkg::*;

    data_t  regs [reg_count];
    flags_t flags_q;
    logic   reg_we;
    logic   fl_we;

    // writeback enables, out of range and r0 writes dropped
    assign reg_we = wb.valid && wb.reg_wr && (wb.rd != '0) && (int'(wb.rd) < reg_count);
    assign fl_we  = wb.valid && wb.fl_write;

    // one read port, with write-through from writeback
    function automatic data_t read_port(reg_idx_t sel);
        data_t val;
        if (sel == '0 || int'(sel) >= reg_count) begin
            val = '0;
        end else if (reg_we && wb.rd == sel) begin
            val = wb.data;
        end else begin
            val = regs[sel];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    // flags bypass too
    assign flags = fl_we ? wb.flags : flags_q;

    //////////////////////////////////////////////////
    // state update
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            flags_q <= '0;
        end else begin
            if (reg_we) begin
                regs[wb.rd] <= wb.data;
            end
            if (fl_we) begin
                flags_q <= wb.flags;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [0:0]
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire payload_t d,
    output      payload_t q
);

    // whole payload cleared so valid drops on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- source/hazard_forward.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_forward (
    input  wire pipe_pkg::de_ex_t   deex,
    input  wire pipe_pkg::result_t  exme,
    input  wire pipe_pkg::result_t  mewb,
    output      pipe_pkg::fwd_sel_t fwd_a,
    output      pipe_pkg::fwd_sel_t fwd_b,
    output      pipe_pkg::fwd_sel_t fwd_fl
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // producer writes the source register, r0 never matches
    function automatic logic reg_hit(reg_idx_t src, result_t st);
        return st.valid && st.reg_wr && (st.rd == src) && (src != '0);
    endfunction

    // youngest producer wins
    function automatic fwd_sel_t pick_reg(reg_idx_t src);
        fwd_sel_t sel;
        if (reg_hit(src, exme)) begin
            sel = from_exme;
        end else if (reg_hit(src, mewb)) begin
            sel = from_mewb;
        end else begin
            sel = from_stage;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_reg(deex.rs1);
        fwd_b = pick_reg(deex.rs2);

        // flags follow the same order
        if (exme.valid && exme.fl_write) begin
            fwd_fl = from_exme;
        end else if (mewb.valid && mewb.fl_write) begin
            fwd_fl = from_mewb;
        end else begin
            fwd_fl = from_stage;
        end
    end

endmodule

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  wire pipe_pkg::de_ex_t   deex,
    input  wire pipe_pkg::result_t  exme,
    input  wire pipe_pkg::result_t  mewb,
    input  wire pipe_pkg::fwd_sel_t fwd_a,
    input  wire pipe_pkg::fwd_sel_t fwd_b,
    input  wire pipe_pkg::fwd_sel_t fwd_fl,
    output      pipe_pkg::result_t  result
);

    import isa_pkg::*;
    import pipe_pkg::*;

    data_t  op_a;
    data_t  op_b;
    data_t  alu_b;
    data_t  alu_out;
    flags_t cur_flags;
    flags_t new_flags;

    //////////////////////////////////////////////////
    // operand muxes
    always_comb begin
        case (fwd_a)
            from_exme: op_a = exme.data;
            from_mewb: op_a = mewb.data;
            default:   op_a = deex.rs1_data;
        endcase
        case (fwd_b)
            from_exme: op_b = exme.data;
            from_mewb: op_b = mewb.data;
            default:   op_b = deex.rs2_data;
        endcase
        case (fwd_fl)
            from_exme: cur_flags = exme.flags;
            from_mewb: cur_flags = mewb.flags;
            default:   cur_flags = deex.flags;
        endcase
    end

    // addi takes the immediate
    assign alu_b = deex.use_imm ? deex.imm : op_b;

    //////////////////////////////////////////////////
    // alu
    always_comb begin
        case (deex.alu_op)
            alu_add:   alu_out = op_a + alu_b;
            alu_sub:   alu_out = op_a - alu_b;
            alu_and:   alu_out = op_a & alu_b;
            alu_or:    alu_out = op_a | alu_b;
            alu_xor:   alu_out = op_a ^ alu_b;
            alu_flags: alu_out = {{(xlen-2){1'b0}}, cur_flags};
            default:   alu_out = '0;
        endcase
    end

    // compare flags come from the subtract result
    always_comb begin
        new_flags          = '0;
        new_flags[fl_zero] = (alu_out == '0);
        new_flags[fl_neg]  = alu_out[xlen-1];
    end

    always_comb begin
        result.valid    = deex.valid;
        result.reg_wr   = deex.reg_wr;
        result.rd       = deex.rd;
        result.data     = alu_out;
        result.fl_write = deex.fl_write;
        // non-compare ops just carry current flags along
        result.flags    = deex.fl_write ? new_flags : cur_flags;
    end

endmodule

`default_nettype wire

//--- source/cpu_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_pipeline #(
    parameter int reg_count = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              instr_valid,
    input  wire isa_pkg::data_t    instr,
    output      logic              wb_valid,
    output      isa_pkg::reg_idx_t wb_sel,
    output      isa_pkg::data_t    wb_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // decode side
    reg_idx_t rs1_sel;
    reg_idx_t rs2_sel;
    data_t    rs1_data;
    data_t    rs2_data;
    flags_t   arch_flags;
    de_ex_t   decoded;

    // stage outputs
    de_ex_t   deex;
    result_t  ex_result;
    result_t  exme;
    result_t  mewb;

    // forwarding selects
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fwd_sel_t fwd_fl;

    //////////////////////////////////////////////////
    // decode and register read
    decoder i_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1         (rs1_sel),
        .rs2         (rs2_sel),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .flags       (arch_flags),
        .decoded     (decoded)
    );

    // written from mewb
    register_file #(.reg_count(reg_count)) i_register_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1_sel),
        .rs2      (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (mewb),
        .flags    (arch_flags)
    );

    stage_reg #(.payload_t(de_ex_t)) i_deex (
        .clk (clk),
        .rst (rst),
        .d   (decoded),
        .q   (deex)
    );

    //////////////////////////////////////////////////
    // execute with forwarding
    hazard_forward i_hazard_forward (
        .deex   (deex),
        .exme   (exme),
        .mewb   (mewb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .fwd_fl (fwd_fl)
    );

    execute i_execute (
        .deex   (deex),
        .exme   (exme),
        .mewb   (mewb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .fwd_fl (fwd_fl),
        .result (ex_result)
    );

    //////////////////////////////////////////////////
    // late stages, plain delay
    stage_reg #(.payload_t(result_t)) i_exme (
        .clk (clk),
        .rst (rst),
        .d   (ex_result),
        .q   (exme)
    );

    stage_reg #(.payload_t(result_t)) i_mewb (
        .clk (clk),
        .rst (rst),
        .d   (exme),
        .q   (mewb)
    );

    // writeback strobe only for register writes
    assign wb_valid = mewb.valid & mewb.reg_wr;
    assign wb_sel   = mewb.rd;
    assign wb_data  = mewb.data;

endmodule

`default_nettype wire

//--- testbench/cpu_pipeline_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_pipeline_chk (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              wb_valid,
    input wire isa_pkg::reg_idx_t wb_sel,
    input wire isa_pkg::data_t    wb_data
);

    // count of failed assertions
    int err_count = 0;

    // r0 writes never reach the strobe
    a_sel_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (wb_sel != '0))
        else begin
            err_count = err_count + 1;
            $error("writeback strobe with register 0 selected");
        end

    // pipeline comes out of reset empty
    a_idle_after_rst: assert property (@(posedge clk) rst |=> !wb_valid)
        else begin
            err_count = err_count + 1;
            $error("writeback strobe high right after reset");
        end

    // no x on the data bus during writeback
    a_data_known: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> !$isunknown(wb_data))
        else begin
            err_count = err_count + 1;
            $error("unknown writeback data");
        end

endmodule

`default_nettype wire

//--- testbench/tb_cpu_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_pipeline;

    import isa_pkg::*;

    localparam int period     = 100;
    localparam int rst_cycles = 5;
    localparam int pipe_depth = 3;
    localparam int n_random   = 48;

    // table row with stimulus and expected writeback
    typedef struct packed {
        logic     iv;
        data_t    instr;
        logic     v;
        reg_idx_t sel;
        data_t    data;
    } entry_t;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    data_t    instr;
    logic     wb_valid;
    reg_idx_t wb_sel;
    data_t    wb_data;

    entry_t   tests[$];
    string    names[$];
    int       pending[$];
    logic     table_ready;

    // reference architectural state
    data_t    ref_regs [32];
    flags_t   ref_flags;
    logic [31:0] rng;

    cpu_pipeline #(.reg_count(32)) i_cpu_pipeline (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

    bind cpu_pipeline cpu_pipeline_chk i_chk (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // pack fields into an instruction word
    function automatic data_t enc(opcode_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                  logic [imm_w-1:0] imm);
        instr_t f;
        f.opcode = op;
        f.rd     = rd;
        f.rs1    = rs1;
        f.rs2    = rs2;
        f.imm    = imm;
        return f;
    endfunction

    // isa-level model stepping one instruction per call
    task automatic model_step(input logic iv, input data_t word, output logic v,
                              output reg_idx_t sel, output data_t data);
        instr_t f;
        data_t  a;
        data_t  b;
        data_t  res;
        logic   wr;
        f   = word;
        a   = ref_regs[f.rs1];
        b   = ref_regs[f.rs2];
        res = '0;
        wr  = 1'b0;
        if (iv) begin
            case (f.opcode)
                op_add: begin
                    res = a + b;
                    wr  = 1'b1;
                end
                op_sub: begin
                    res = a - b;
                    wr  = 1'b1;
                end
                op_and: begin
                    res = a & b;
                    wr  = 1'b1;
                end
                op_or: begin
                    res = a | b;
                    wr  = 1'b1;
                end
                op_xor: begin
                    res = a ^ b;
                    wr  = 1'b1;
                end
                op_addi: begin
                    res = a + {{(xlen-imm_w){f.imm[imm_w-1]}}, f.imm};
                    wr  = 1'b1;
                end
                op_cmp: begin
                    res = a - b;
                    ref_flags[fl_zero] = (res == '0);
                    ref_flags[fl_neg]  = res[xlen-1];
                end
                op_rdfl: begin
                    res = {{(xlen-2){1'b0}}, ref_flags};
                    wr  = 1'b1;
                end
                default: wr = 1'b0;
            endcase
        end
        // r0 stays zero and gives no writeback
        v = wr && (f.rd != '0);
        if (v) begin
            ref_regs[f.rd] = res;
        end
        sel  = f.rd;
        data = res;
    endtask

    task automatic add_wb(string name, data_t word, reg_idx_t sel, data_t data);
        tests.push_back('{1'b1, word, 1'b1, sel, data});
        names.push_back(name);
    endtask

    // rows that must not write back
    task automatic add_silent(string name, logic iv, data_t word);
        tests.push_back('{iv, word, 1'b0, 5'd0, 32'd0});
        names.push_back(name);
    endtask

    //////////////////////////////////////////////////
    // stimulus table

    task automatic build_table();
        logic        v;
        reg_idx_t    sel;
        data_t       data;
        logic [31:0] r;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        data_t       word;
        // idle after reset, then a nop
        add_silent("idle0", 1'b0, '0);
        add_silent("idle1", 1'b0, '0);
        add_silent("nop", 1'b1, enc(op_nop, 5'd5, 5'd1, 5'd2, 12'd0));
        // seed registers
        add_wb("addi_r1", enc(op_addi, 5'd1, 5'd0, 5'd0, 12'd100), 5'd1, 32'd100);
        add_wb("addi_r2", enc(op_addi, 5'd2, 5'd0, 5'd0, 12'hff9), 5'd2, 32'hffff_fff9);
        add_wb("addi_r3", enc(op_addi, 5'd3, 5'd0, 5'd0, 12'h03c), 5'd3, 32'd60);
        add_silent("gap0", 1'b0, '0);
        add_silent("gap1", 1'b0, '0);
        add_silent("gap2", 1'b0, '0);
        // independent alu ops
        add_wb("add_r4", enc(op_add, 5'd4, 5'd1, 5'd2, 12'd0), 5'd4, 32'd93);
        add_wb("sub_r5", enc(op_sub, 5'd5, 5'd1, 5'd2, 12'd0), 5'd5, 32'd107);
        add_wb("and_r6", enc(op_and, 5'd6, 5'd1, 5'd3, 12'd0), 5'd6, 32'h24);
        add_wb("or_r7", enc(op_or, 5'd7, 5'd1, 5'd3, 12'd0), 5'd7, 32'h7c);
        add_wb("xor_r8", enc(op_xor, 5'd8, 5'd1, 5'd3, 12'd0), 5'd8, 32'h58);
        // dependency chain at distances 1, 2 and 3
        add_wb("dep_r9", enc(op_addi, 5'd9, 5'd0, 5'd0, 12'd5), 5'd9, 32'd5);
        add_wb("dep_d1", enc(op_addi, 5'd10, 5'd9, 5'd0, 12'd1), 5'd10, 32'd6);
        add_wb("dep_d2", enc(op_add, 5'd11, 5'd9, 5'd10, 12'd0), 5'd11, 32'd11);
        add_wb("dep_d3", enc(op_add, 5'd12, 5'd9, 5'd11, 12'd0), 5'd12, 32'd16);
        add_wb("dep_mix", enc(op_sub, 5'd13, 5'd12, 5'd10, 12'd0), 5'd13, 32'd10);
        // flags through exme, mewb, write-through, then register
        add_silent("cmp_eq", 1'b1, enc(op_cmp, 5'd0, 5'd1, 5'd1, 12'd0));
        add_wb("rdfl_d1", enc(op_rdfl, 5'd14, 5'd0, 5'd0, 12'd0), 5'd14, 32'd1);
        add_silent("cmp_neg", 1'b1, enc(op_cmp, 5'd0, 5'd2, 5'd1, 12'd0));
        add_silent("gap3", 1'b0, '0);
        add_wb("rdfl_d2", enc(op_rdfl, 5'd15, 5'd0, 5'd0, 12'd0), 5'd15, 32'd2);
        add_silent("cmp_eq2", 1'b1, enc(op_cmp, 5'd0, 5'd2, 5'd2, 12'd0));
        add_silent("gap4", 1'b0, '0);
        add_silent("gap5", 1'b0, '0);
        add_wb("rdfl_d3", enc(op_rdfl, 5'd16, 5'd0, 5'd0, 12'd0), 5'd16, 32'd1);
        add_wb("rdfl_d4", enc(op_rdfl, 5'd17, 5'd0, 5'd0, 12'd0), 5'd17, 32'd1);
        // register 0
        add_silent("wr_r0_addi", 1'b1, enc(op_addi, 5'd0, 5'd1, 5'd0, 12'd1));
        add_wb("rd_r0_add", enc(op_add, 5'd18, 5'd0, 5'd1, 12'd0), 5'd18, 32'd100);
        add_silent("wr_r0_add", 1'b1, enc(op_add, 5'd0, 5'd1, 5'd2, 12'd0));
        add_wb("rd_r0_or", enc(op_or, 5'd19, 5'd0, 5'd0, 12'd0), 5'd19, 32'd0);

        // bring the model up to date with the directed rows
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        ref_flags = '0;
        foreach (tests[i]) begin
            model_step(tests[i].iv, tests[i].instr, v, sel, data);
        end

        // random stream on r20..r27 so dependencies are dense
        rng = 32'h3804_2049;
        for (int i = 0; i < n_random; i++) begin
            rng  = xorshift(rng);
            r    = rng;
            rd   = 5'd20 + {2'b00, r[2:0]};
            ra   = 5'd20 + {2'b00, r[5:3]};
            rb   = 5'd20 + {2'b00, r[8:6]};
            word = enc(r[31] ? op_add : op_addi, rd, ra, rb, r[20:9]);
            model_step(1'b1, word, v, sel, data);
            tests.push_back('{1'b1, word, v, sel, data});
            names.push_back($sformatf("rand_%0d", i));
        end
    endtask

    //////////////////////////////////////////////////
    // checking

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_valid(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s wb_valid: expected %b actual %b", name, exp, act);
            abort_run("writeback strobe wrong");
        end
    endtask

    task automatic check_sel(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH %s wb_sel: expected %0d actual %0d", name, exp, act);
            abort_run("writeback register wrong");
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s wb_data: expected %08h actual %08h", name, exp, act);
            abort_run("writeback data wrong");
        end
    endtask

    task automatic check_entry(int idx);
        entry_t e;
        e = tests[idx];
        check_valid(names[idx], e.v, wb_valid);
        if (e.v) begin
            check_sel(names[idx], e.sel, wb_sel);
            check_data(names[idx], e.data, wb_data);
        end
    endtask

    // bound from the table length
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(rst_cycles + tests.size() + pipe_depth) * 2 * period;
        #(limit_ns);
        abort_run("watchdog expired before the table finished");
    end

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        int n;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        table_ready = 1'b0;
        build_table();
        n           = tests.size();
        table_ready = 1'b1;

        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;

        // check 3 edges behind, then drive the next row
        for (int cyc = 0; cyc < n + pipe_depth; cyc++) begin
            if (i_cpu_pipeline.i_chk.err_count != 0) begin
                abort_run("an assertion on the writeback outputs failed");
            end
            if (cyc >= pipe_depth) begin
                check_entry(pending.pop_front());
            end else begin
                check_valid("after_reset", 1'b0, wb_valid);
            end
            if (cyc < n) begin
                instr_valid = tests[cyc].iv;
                instr       = tests[cyc].instr;
                pending.push_back(cyc);
            end else begin
                instr_valid = 1'b0;
                instr       = '0;
            end
            @(negedge clk);
        end

        if (i_cpu_pipeline.i_chk.err_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("an assertion on the writeback outputs failed");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/decoder.sv
source/register_file.sv
source/stage_reg.sv
source/hazard_forward.sv
source/execute.sv
source/cpu_pipeline.sv
testbench/cpu_pipeline_chk.sv
testbench/tb_cpu_pipeline.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --top-module tb_cpu_pipeline \
		--Mdir $(OBJ_DIR) -o tb_cpu_pipeline -f sim.f
	./$(OBJ_DIR)/tb_cpu_pipeline

clean:
	rm -rf $(OBJ_DIR)
